// File: tb.f
+incdir+rtl
rtl/nnDataPkg.sv
rtl/nnCtrlPkg.sv
rtl/featureCollector.sv
rtl/neuronNode.sv
rtl/neuronLayer.sv
rtl/resultBuffer.sv
rtl/resultSerializer.sv
rtl/nnLayerTop.sv
dv/nnLayer_asserts.sv
dv/nnChecker.sv
dv/tb_nnLayer.sv

// File: run.sh
#!/bin/sh
# Build and run the nnLayer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nnLayer -f tb.f -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simv +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// File: dv/tb_nnLayer.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module tb_nnLayer;

	localparam int DRAIN_TIMEOUT = 1000;
	localparam int OVERFLOW_TIMEOUT = 200;
	localparam int FLUSH_CYCLES = 6; // Collector, layer and push latency with margin

	logic clk;
	logic reset;
	logic sampleStrobe;
	nnDataPkg::sample_t sampleData;
	logic outHold;
	logic outStrobe;
	nnDataPkg::sample_t outData;
	logic [1:0] outIndex;
	logic overflow;

	int testId;
	logic expectDrops;
	logic overflowCheck;
	int errorCount;
	int checkCount;
	int pendingWords;
	int timeouts;
	int assertFails;
	logic timedOut;
	logic stimDone;

	nnLayerTop uut (
		.clk          (clk),
		.reset        (reset),
		.sampleStrobe (sampleStrobe),
		.sampleData   (sampleData),
		.outHold      (outHold),
		.outStrobe    (outStrobe),
		.outData      (outData),
		.outIndex     (outIndex),
		.overflow     (overflow)
	);

	nnChecker chk (
		.clk           (clk),
		.reset         (reset),
		.sampleStrobe  (sampleStrobe),
		.sampleData    (sampleData),
		.outStrobe     (outStrobe),
		.outData       (outData),
		.outIndex      (outIndex),
		.overflow      (overflow),
		.testId        (testId),
		.expectDrops   (expectDrops),
		.overflowCheck (overflowCheck),
		.errorCount    (errorCount),
		.checkCount    (checkCount),
		.pendingWords  (pendingWords)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic sendVector(input nnDataPkg::featureVec_t v, input int gap);
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			@(negedge clk);
			sampleStrobe = 1'b1;
			sampleData = v.x[i];
			for (int g = 0; g < gap; g++)
			begin
				@(negedge clk);
				sampleStrobe = 1'b0;
			end
		end
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			sampleStrobe = 1'b0;
		end
	endtask

	function automatic nnDataPkg::featureVec_t randomVector(input int span);
		nnDataPkg::featureVec_t v;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			if (span == 0)
				v.x[i] = nnDataPkg::sample_t'($urandom); // Full range
			else
				v.x[i] = nnDataPkg::sample_t'(int'($urandom % (2 * span + 1)) - span);
		end
		return v;
	endfunction

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (pendingWords != 0 && cycles < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (pendingWords != 0)
		begin
			timeouts++;
			timedOut = 1'b1;
			$display("Timeout in test %0d: %0d output words still missing after %0d cycles",
				testId, pendingWords, DRAIN_TIMEOUT);
		end
	endtask

	task automatic waitOverflow();
		int cycles;
		cycles = 0;
		while (!overflow && cycles < OVERFLOW_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!overflow)
		begin
			timeouts++;
			timedOut = 1'b1;
			$display("Timeout in test %0d: overflow never went high", testId);
		end
	endtask

	task automatic pulseOverflowCheck();
		@(negedge clk);
		overflowCheck = 1'b1;
		@(negedge clk);
		overflowCheck = 1'b0;
	endtask

	task automatic runTests();
		nnDataPkg::featureVec_t v;

		testId = 1;
		v = '0;
		sendVector(v, 0);
		for (int i = 0; i < `NUM_INPUTS; i++)
			v.x[i] = 16'sd1;
		sendVector(v, 0);
		for (int k = 0; k < `NUM_INPUTS; k++)
		begin
			v = '0;
			v.x[k] = 16'sd1000;
			sendVector(v, 0);
		end
		for (int i = 0; i < `NUM_INPUTS; i++)
			v.x[i] = (i % 2 == 1) ? 16'sh8000 : 16'sh7fff; // Forces wraparound
		sendVector(v, 0);
		for (int i = 0; i < `NUM_INPUTS; i++)
			v.x[i] = 16'sh7fff;
		sendVector(v, 1);
		idleCycles(2);
		waitDrained();
		if (timedOut)
			return;

		testId = 2;
		for (int i = 0; i < `NUM_INPUTS; i++)
			v.x[i] = 16'sd10; // Node 2 goes negative
		sendVector(v, 0);
		for (int i = 0; i < `NUM_INPUTS; i++)
			v.x[i] = -16'sd10;
		sendVector(v, 0);
		for (int r = 0; r < 4; r++)
			sendVector(randomVector(100), 0);
		idleCycles(2);
		waitDrained();
		if (timedOut)
			return;

		testId = 3;
		for (int r = 0; r < 10; r++)
			sendVector(randomVector(0), 0);
		idleCycles(2);
		waitDrained();
		if (timedOut)
			return;

		testId = 4;
		stimDone = 1'b0;
		fork
			begin
				for (int r = 0; r < 8; r++)
					sendVector(randomVector(0), 2);
				idleCycles(1);
				stimDone = 1'b1;
			end
			begin
				for (int c = 0; c < 2000 && !stimDone; c++)
				begin
					@(negedge clk);
					outHold = ($urandom % 4 == 0);
				end
			end
		join
		@(negedge clk);
		outHold = 1'b0;
		waitDrained();
		if (timedOut)
			return;
		pulseOverflowCheck();

		testId = 5;
		expectDrops = 1'b1;
		@(negedge clk);
		outHold = 1'b1; // Serializer is idle here
		for (int r = 0; r < 6; r++)
			sendVector(randomVector(0), 0);
		idleCycles(1);
		waitOverflow();
		if (timedOut)
			return;
		idleCycles(FLUSH_CYCLES);
		outHold = 1'b0;
		waitDrained();
		if (timedOut)
			return;
		pulseOverflowCheck();
	endtask

	initial
	begin
		void'($urandom(32'hf18c));
		reset = 1'b1;
		sampleStrobe = 1'b0;
		sampleData = '0;
		outHold = 1'b0;
		testId = 0;
		expectDrops = 1'b0;
		overflowCheck = 1'b0;
		timeouts = 0;
		timedOut = 1'b0;
		stimDone = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		runTests();

		@(negedge clk);
		assertFails = uut.protocolChecks.failCount;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
			checkCount, errorCount, assertFails, timeouts);
		if (errorCount == 0 && assertFails == 0 && timeouts == 0 && checkCount > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/nnChecker.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module nnChecker (
	input  logic               clk,
	input  logic               reset,
	input  logic               sampleStrobe,
	input  nnDataPkg::sample_t sampleData,
	input  logic               outStrobe,
	input  nnDataPkg::sample_t outData,
	input  logic [1:0]         outIndex,
	input  logic               overflow,
	input  int                 testId,
	input  logic               expectDrops,
	input  logic               overflowCheck,
	output int                 errorCount,
	output int                 checkCount,
	output int                 pendingWords
);

	typedef struct packed {
		logic [1:0]         index;
		nnDataPkg::sample_t value;
	} expWord_t;

	expWord_t expQ [$];
	nnDataPkg::featureVec_t collected;
	logic [$clog2(`NUM_INPUTS)-1:0] slot;
	int droppedVectors;
	logic overflowReported;

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		pendingWords = 0;
		droppedVectors = 0;
		overflowReported = 1'b0;
		slot = '0;
		collected = '0;
	end

	function automatic string testName(input int id);
		case (id)
			1: return "directed";
			2: return "relu";
			3: return "backToBack";
			4: return "holdToggle";
			5: return "holdOverflow";
			default: return "reset";
		endcase
	endfunction

	// Low 16 bits of each product, sum wraps, negative clamps to zero
	function automatic nnDataPkg::sample_t refNeuron(input int node,
		input nnDataPkg::featureVec_t v);
		logic [15:0] total;
		int prod;
		total = nnDataPkg::biasOf(node);
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			prod = int'(v.x[i]) * int'(nnDataPkg::weightOf(node, i));
			total = total + prod[15:0];
		end
		return total[15] ? '0 : nnDataPkg::sample_t'(total);
	endfunction

	task automatic queueVector(input nnDataPkg::featureVec_t v);
		expWord_t word;
		// Output held from idle, so the queue mirrors buffer occupancy
		if (expectDrops && (expQ.size() / `NUM_NEURONS) >= `BUF_DEPTH)
			droppedVectors++;
		else
		begin
			for (int n = 0; n < `NUM_NEURONS; n++)
			begin
				word.index = 2'(n);
				word.value = refNeuron(n, v);
				expQ.push_back(word);
			end
		end
	endtask

	task automatic compareWord();
		expWord_t want;
		if (expQ.size() == 0)
		begin
			errorCount++;
			$display("Output word at index %0d arrived with nothing expected in test %s",
				outIndex, testName(testId));
		end
		else
		begin
			want = expQ.pop_front();
			checkCount++;
			if (outIndex !== want.index || outData !== want.value)
			begin
				errorCount++;
				$display("[FAIL] %s: expected index %0d value %0d, actual index %0d value %0d",
					testName(testId), want.index, want.value, outIndex, outData);
			end
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
			slot = '0;
		else
		begin
			if (outStrobe)
				compareWord();
			if (sampleStrobe)
			begin
				collected.x[slot] = sampleData; // First sample is input 0
				if (slot == ($clog2(`NUM_INPUTS))'(`NUM_INPUTS - 1))
				begin
					slot = '0;
					queueVector(collected);
				end
				else
					slot = slot + 1'b1;
			end
			if (overflow && !expectDrops && !overflowReported)
			begin
				errorCount++;
				overflowReported = 1'b1;
				$display("Overflow went high in test %s although no drops were expected",
					testName(testId));
			end
			if (overflowCheck)
			begin
				checkCount++;
				if (overflow !== (droppedVectors > 0))
				begin
					errorCount++;
					$display("[FAIL] %s: expected overflow %0d, actual overflow %0d",
						testName(testId), droppedVectors > 0, overflow);
				end
			end
		end
		pendingWords = expQ.size();
	end

endmodule

`default_nettype wire

// File: dv/nnLayer_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module nnLayerAsserts (
	input logic       clk,
	input logic       reset,
	input logic       outHold,
	input logic       outStrobe,
	input logic [1:0] outIndex,
	input logic       overflow
);

	int failCount = 0;

	quietAfterReset: assert property (@(posedge clk) reset |=> !outStrobe)
		else
		begin
			failCount++;
			$error("outStrobe high during reset or in the cycle after it");
		end

	// A held cycle emits nothing and keeps the index
	quietWhileHeld: assert property (@(posedge clk) disable iff (reset)
		outHold |=> !$past(outStrobe) && $stable(outIndex))
		else
		begin
			failCount++;
			$error("outStrobe high or outIndex moved while outHold is high");
		end

	// Index wraps from 3 back to 0 between vectors
	indexSteps: assert property (@(posedge clk) disable iff (reset)
		outStrobe |=> outIndex == 2'($past(outIndex) + 2'd1))
		else
		begin
			failCount++;
			$error("outIndex did not advance by one after an output word");
		end

	overflowSticky: assert property (@(posedge clk) disable iff (reset) overflow |=> overflow)
		else
		begin
			failCount++;
			$error("overflow fell without a reset");
		end

endmodule

bind nnLayerTop nnLayerAsserts protocolChecks (
	.clk       (clk),
	.reset     (reset),
	.outHold   (outHold),
	.outStrobe (outStrobe),
	.outIndex  (outIndex),
	.overflow  (overflow)
);

`default_nettype wire

// File: rtl/nnLayerTop.sv
`default_nettype none
`timescale 1ns/1ps

module nnLayerTop (
	input  logic                clk,
	input  logic                reset,
	input  logic                sampleStrobe,
	input  nnDataPkg::sample_t  sampleData,
	input  logic                outHold,
	output logic                outStrobe,
	output nnDataPkg::sample_t  outData,
	output logic [1:0]          outIndex,
	output logic                overflow
);

	logic vectorStrobe;
	nnDataPkg::featureVec_t vector;
	logic resultStrobe;
	nnDataPkg::layerResult_t result;
	logic pop;
	nnDataPkg::layerResult_t head;
	logic empty;

	featureCollector collector (
		.clk          (clk),
		.reset        (reset),
		.sampleStrobe (sampleStrobe),
		.sampleData   (sampleData),
		.vectorStrobe (vectorStrobe),
		.vector       (vector)
	);

	neuronLayer layer (
		.clk          (clk),
		.reset        (reset),
		.vectorStrobe (vectorStrobe),
		.vector       (vector),
		.resultStrobe (resultStrobe),
		.result       (result)
	);

	resultBuffer buffer (
		.clk      (clk),
		.reset    (reset),
		.push     (resultStrobe),
		.pushData (result),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	resultSerializer serializer (
		.clk       (clk),
		.reset     (reset),
		.empty     (empty),
		.head      (head),
		.outHold   (outHold),
		.pop       (pop),
		.outStrobe (outStrobe),
		.outData   (outData),
		.outIndex  (outIndex)
	);

endmodule

`default_nettype wire

// File: rtl/resultSerializer.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module resultSerializer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     empty,
	input  nnDataPkg::layerResult_t  head,
	input  logic                     outHold,
	output logic                     pop,
	output logic                     outStrobe,
	output nnDataPkg::sample_t       outData,
	output logic [1:0]               outIndex
);

	nnCtrlPkg::serialState_e state;
	nnDataPkg::layerResult_t holdReg;
	logic [1:0] index;

	assign pop       = (state == nnCtrlPkg::idle) && !empty && !outHold;
	assign outStrobe = (state == nnCtrlPkg::send) && !outHold;
	assign outData   = holdReg.y[index];
	assign outIndex  = index;

	always_ff @(posedge clk)
	begin
		if (pop)
			holdReg <= head; // Local copy frees the buffer slot
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnCtrlPkg::idle;
			index <= '0;
		end
		else
		begin
			case (state)
				nnCtrlPkg::idle:
				begin
					index <= '0;
					if (pop)
						state <= nnCtrlPkg::send;
				end
				nnCtrlPkg::send:
				begin
					if (outStrobe)
					begin
						if (index == 2'(`NUM_NEURONS - 1))
						begin
							index <= '0;
							state <= nnCtrlPkg::idle;
						end
						else
							index <= index + 1'b1;
					end
				end
				default: state <= nnCtrlPkg::idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/resultBuffer.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module resultBuffer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     push,
	input  nnDataPkg::layerResult_t  pushData,
	input  logic                     pop,
	output nnDataPkg::layerResult_t  head,
	output logic                     empty,
	output logic                     overflow
);

	localparam int PTR_W = $clog2(`BUF_DEPTH);
	localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

	nnDataPkg::layerResult_t mem [`BUF_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic full;
	logic doPush;
	logic doPop;

	assign full   = (count == CNT_W'(`BUF_DEPTH));
	assign empty  = (count == '0);
	assign doPush = push && !full; // Pushes while full are lost
	assign doPop  = pop && !empty;
	assign head   = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full)
				overflow <= 1'b1; // Sticky until reset
		end
	end

endmodule

`default_nettype wire

// File: rtl/neuronLayer.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module neuronLayer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     vectorStrobe,
	input  nnDataPkg::featureVec_t   vector,
	output logic                     resultStrobe,
	output nnDataPkg::layerResult_t  result
);

	logic [2:0] strobePipe;

	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : genNode
		neuronNode #(
			.NODE_INDEX (n)
		) node (
			.clk    (clk),
			.reset  (reset),
			.vector (vector),
			.value  (result.y[n])
		);
	end

	// One bit per node register stage
	always_ff @(posedge clk)
	begin
		if (reset)
			strobePipe <= '0;
		else
			strobePipe <= {strobePipe[1:0], vectorStrobe};
	end

	assign resultStrobe = strobePipe[2];

endmodule

`default_nettype wire

// File: rtl/neuronNode.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module neuronNode #(
	parameter int NODE_INDEX = 0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  nnDataPkg::featureVec_t  vector,
	output nnDataPkg::sample_t      value
);

	nnDataPkg::featureVec_t inReg;
	nnDataPkg::sample_t acc;
	nnDataPkg::sample_t sum;

	always_ff @(posedge clk)
	begin
		inReg <= vector; // Stage 1
	end

	// Products keep their low bits only, the sum wraps at the word width
	always_comb
	begin
		acc = nnDataPkg::biasOf(NODE_INDEX);
		for (int i = 0; i < `NUM_INPUTS; i++)
			acc = acc + inReg.x[i] * nnDataPkg::weightOf(NODE_INDEX, i);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum   <= '0;
			value <= '0;
		end
		else
		begin
			sum   <= acc; // Stage 2
			value <= sum[`DATA_WIDTH-1] ? '0 : sum; // Stage 3, ReLU
		end
	end

endmodule

`default_nettype wire

// File: rtl/featureCollector.sv
`default_nettype none
`timescale 1ns/1ps
`include "nn_defines.svh"

module featureCollector (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    sampleStrobe,
	input  nnDataPkg::sample_t      sampleData,
	output logic                    vectorStrobe,
	output nnDataPkg::featureVec_t  vector
);

	localparam int COUNT_W = $clog2(`NUM_INPUTS);

	nnCtrlPkg::collectState_e state;
	logic [COUNT_W-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnCtrlPkg::collect;
			count <= '0;
		end
		else
		begin
			state <= nnCtrlPkg::collect; // Emit lasts one cycle
			if (sampleStrobe)
			begin
				if (count == COUNT_W'(`NUM_INPUTS - 1))
				begin
					count <= '0;
					state <= nnCtrlPkg::emit;
				end
				else
					count <= count + 1'b1;
			end
		end
	end

	// Newest sample enters at the top, so the oldest ends up at input 0
	always_ff @(posedge clk)
	begin
		if (sampleStrobe)
			vector.x <= {sampleData, vector.x[`NUM_INPUTS-1:1]};
	end

	assign vectorStrobe = (state == nnCtrlPkg::emit);

endmodule

`default_nettype wire

// File: rtl/nnCtrlPkg.sv
`default_nettype none

package nnCtrlPkg;

	// Collector: gathering samples, or presenting a full vector
	typedef enum logic {
		collect,
		emit
	} collectState_e;

	// Serializer: waiting for a vector, or stepping through its values
	typedef enum logic {
		idle,
		send
	} serialState_e;

endpackage

`default_nettype wire

// File: rtl/nnDataPkg.sv
`default_nettype none
`include "nn_defines.svh"

package nnDataPkg;

	typedef logic signed [`DATA_WIDTH-1:0] sample_t;

	typedef struct packed {
		sample_t [`NUM_INPUTS-1:0] x; // Input 0 is the first sample received
	} featureVec_t;

	typedef struct packed {
		sample_t [`NUM_NEURONS-1:0] y; // One value per node
	} layerResult_t;

	// Row per node, column per input
	localparam sample_t weightTable [`NUM_NEURONS][`NUM_INPUTS] = '{
		'{16'sd27, -16'sd131, 16'sd443, 16'sd450, -16'sd96, 16'sd308, 16'sd123, -16'sd209},
		'{-16'sd259, 16'sd145, 16'sd66, -16'sd380, 16'sd747, 16'sd160, 16'sd277, 16'sd11},
		'{16'sd373, -16'sd563, 16'sd160, 16'sd192, -16'sd493, -16'sd118, 16'sd75, 16'sd34},
		'{16'sd533, -16'sd427, 16'sd354, -16'sd529, 16'sd88, 16'sd201, -16'sd62, 16'sd15}
	};

	localparam sample_t biasTable [`NUM_NEURONS] = '{16'sd27, -16'sd40, 16'sd12, 16'sd100};

	function automatic sample_t weightOf(input int node, input int idx);
		return weightTable[node][idx];
	endfunction

	function automatic sample_t biasOf(input int node);
		return biasTable[node];
	endfunction

endpackage

`default_nettype wire

// File: rtl/nn_defines.svh
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// Sample, weight and result width
`define DATA_WIDTH 16

// Samples per feature vector
`define NUM_INPUTS 8

// Nodes in the layer
`define NUM_NEURONS 4

// Result vectors held between layer and serializer
`define BUF_DEPTH 4

`endif
